/* design/vram_pkg.sv */
// Video RAM geometry shared by the memory, the bus slave and the fetcher
package vram_pkg;

    // Port A sees the memory as 4096 bytes
    localparam int byte_addr_width = 12;

    // Port B sees the same bytes as 2048 little-endian words
    localparam int word_addr_width = 11;

    localparam int byte_width = 8;
    localparam int word_width = 16;

endpackage

/* design/display_pkg.sv */
// Register map, display mode, cell layout and item widths of the display side
package display_pkg;

    // Bit 12 of the bus address selects register space
    localparam int wb_addr_width = 13;

    localparam int reg_addr_width = 3;

    // Register offsets within register space
    localparam logic [reg_addr_width-1:0] reg_ctrl    = 3'd0;
    localparam logic [reg_addr_width-1:0] reg_base_lo = 3'd1;
    localparam logic [reg_addr_width-1:0] reg_base_hi = 3'd2;
    localparam logic [reg_addr_width-1:0] reg_count   = 3'd3;
    localparam logic [reg_addr_width-1:0] reg_color   = 3'd4;
    localparam logic [reg_addr_width-1:0] reg_status  = 3'd5;

    localparam int item_code_width  = 8;
    localparam int item_color_width = 4;

    typedef enum logic {
        mode_text  = 1'b0,
        mode_pixel = 1'b1
    } display_mode_t;

    // Text cell with the attribute in the high byte and the glyph in the low byte
    typedef struct packed {
        logic [7:0] attr;
        logic [7:0] glyph;
    } text_cell_t;

    // One video word, read as a text cell or as two pixel bytes
    // Pixel element 0 is the low byte and is shown first
    typedef union packed {
        text_cell_t      text;
        logic [1:0][7:0] pixel;
    } display_cell_t;

endpackage

/* design/cfg_bus_if.sv */
// Register access interface between the bus slave and the register block
`timescale 1ns/1ps

interface cfg_bus_if;
    import display_pkg::*;

    logic [reg_addr_width-1:0] addr;
    logic [7:0]                wdata;
    logic                      we;
    // One pulse per register access
    logic                      stb;
    logic [7:0]                rdata;

    modport master (
        output addr,
        output wdata,
        output we,
        output stb,
        input  rdata
    );

    modport target (
        input  addr,
        input  wdata,
        input  we,
        input  stb,
        output rdata
    );

endinterface

/* design/fetch_ctrl_if.sv */
// Control and status interface between the register block and the cell fetcher
`timescale 1ns/1ps

interface fetch_ctrl_if;
    import vram_pkg::*;
    import display_pkg::*;

    // Start and done are single-cycle pulses
    logic                        start;
    display_mode_t               mode;
    logic [word_addr_width-1:0]  base;
    logic [7:0]                  count;
    logic [item_color_width-1:0] color;
    logic                        busy;
    logic                        done;

    modport ctrl (
        output start,
        output mode,
        output base,
        output count,
        output color,
        input  busy,
        input  done
    );

    modport engine (
        input  start,
        input  mode,
        input  base,
        input  count,
        input  color,
        output busy,
        output done
    );

endinterface

/* design/dpram_dif.sv */
// Dual-port RAM with a byte-wide port A and a word-wide port B over one byte array
`timescale 1ns/1ps

module dpram_dif (
    input  logic                                clock,

    // Port A reads and writes single bytes
    input  logic [vram_pkg::byte_addr_width-1:0] address_a,
    input  logic [vram_pkg::byte_width-1:0]      data_a,
    input  logic                                wren_a,
    output logic [vram_pkg::byte_width-1:0]      q_a,

    // Port B reads and writes little-endian byte pairs
    input  logic [vram_pkg::word_addr_width-1:0] address_b,
    input  logic [vram_pkg::word_width-1:0]      data_b,
    input  logic                                wren_b,
    output logic [vram_pkg::word_width-1:0]      q_b
);
    import vram_pkg::*;

    logic [byte_width-1:0] mem [0:(2**byte_addr_width)-1];

    always_ff @(posedge clock) begin
        if (wren_a) begin
            mem[address_a] <= data_a;
        end
        if (wren_b) begin
            mem[{address_b, 1'b0}] <= data_b[byte_width-1:0];
            mem[{address_b, 1'b1}] <= data_b[word_width-1:byte_width];
        end
        // Both read ports return data one cycle after the address
        q_a <= mem[address_a];
        q_b <= {mem[{address_b, 1'b1}], mem[{address_b, 1'b0}]};
    end

    // Port A's byte must not fall inside the word that port B writes
    a_no_write_collision : assert property (
        @(posedge clock)
        !(wren_a && wren_b && (address_a[byte_addr_width-1:1] == address_b))
    ) else $error("dpram_dif: both ports write byte address %0h", address_a);

endmodule

/* design/wb_vram_slave.sv */
// Wishbone classic slave for video RAM bytes and the display register bank
`timescale 1ns/1ps

module wb_vram_slave (
    input  logic                                 clock,
    input  logic                                 rst,

    input  logic                                 wb_cyc,
    input  logic                                 wb_stb,
    input  logic                                 wb_we,
    input  logic [display_pkg::wb_addr_width-1:0] wb_adr,
    input  logic [vram_pkg::byte_width-1:0]       wb_dat_w,
    output logic [vram_pkg::byte_width-1:0]       wb_dat_r,
    output logic                                 wb_ack,

    // RAM port A
    output logic [vram_pkg::byte_addr_width-1:0]  ram_addr,
    output logic [vram_pkg::byte_width-1:0]       ram_wdata,
    output logic                                 ram_we,
    input  logic [vram_pkg::byte_width-1:0]       ram_q,

    cfg_bus_if.master                            cfg
);
    import vram_pkg::*;
    import display_pkg::*;

    // Set during the second cycle of an access
    logic phase;
    logic reg_sel;
    logic req;

    assign reg_sel = wb_adr[wb_addr_width-1];

    // New access only in the first phase, and never in the ack cycle
    assign req = wb_cyc && wb_stb && !wb_ack && !phase;

    // RAM port A follows the bus address directly
    assign ram_addr  = wb_adr[byte_addr_width-1:0];
    assign ram_wdata = wb_dat_w;
    assign ram_we    = req && wb_we && !reg_sel;

    assign cfg.addr  = wb_adr[reg_addr_width-1:0];
    assign cfg.wdata = wb_dat_w;
    assign cfg.we    = wb_we;
    assign cfg.stb   = req && reg_sel;

    always_ff @(posedge clock) begin
        if (rst) begin
            phase  <= 1'b0;
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= 1'b0;
            if (req) begin
                phase <= 1'b1;
            end else if (phase) begin
                phase <= 1'b0;
                // A master that gave up the cycle gets no ack
                wb_ack <= wb_cyc && wb_stb;
            end
        end
    end

    // RAM data is valid in the second phase, one cycle after the address
    always_ff @(posedge clock) begin
        if (phase) begin
            wb_dat_r <= reg_sel ? cfg.rdata : ram_q;
        end
    end

    a_ack_in_cycle : assert property (
        @(posedge clock) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb)
    ) else $error("wb_vram_slave: ack without an active bus cycle");

endmodule

/* design/display_regs.sv */
// Display control, base, count, colour and status registers for the fetcher
`timescale 1ns/1ps

module display_regs (
    input  logic         clock,
    input  logic         rst,
    cfg_bus_if.target    cfg,
    fetch_ctrl_if.ctrl   fetch
);
    import display_pkg::*;

    display_mode_t               mode;
    logic [7:0]                  base_lo;
    logic [2:0]                  base_hi;
    logic [7:0]                  count;
    logic [item_color_width-1:0] color;
    logic                        start;
    logic                        done_flag;
    logic                        wr;

    assign wr = cfg.stb && cfg.we;

    always_ff @(posedge clock) begin
        if (rst) begin
            mode      <= mode_text;
            base_lo   <= '0;
            base_hi   <= '0;
            count     <= '0;
            color     <= '0;
            start     <= 1'b0;
            done_flag <= 1'b0;
        end else begin
            start <= 1'b0;
            if (wr) begin
                case (cfg.addr)
                    reg_ctrl: begin
                        mode  <= display_mode_t'(cfg.wdata[1]);
                        // A start during a running fetch is dropped here
                        start <= cfg.wdata[0] && !fetch.busy;
                    end
                    reg_base_lo: base_lo <= cfg.wdata;
                    reg_base_hi: base_hi <= cfg.wdata[2:0];
                    reg_count:   count   <= cfg.wdata;
                    reg_color:   color   <= cfg.wdata[item_color_width-1:0];
                    default: ;
                endcase
            end
            // Sticky until the next fetch begins
            if (fetch.start) begin
                done_flag <= 1'b0;
            end else if (fetch.done) begin
                done_flag <= 1'b1;
            end
        end
    end

    assign fetch.start = start;
    assign fetch.mode  = mode;
    assign fetch.base  = {base_hi, base_lo};
    assign fetch.count = count;
    assign fetch.color = color;

    always_comb begin
        case (cfg.addr)
            reg_ctrl:    cfg.rdata = {6'b0, mode, 1'b0};
            reg_base_lo: cfg.rdata = base_lo;
            reg_base_hi: cfg.rdata = {5'b0, base_hi};
            reg_count:   cfg.rdata = count;
            reg_color:   cfg.rdata = {{(8 - item_color_width){1'b0}}, color};
            reg_status:  cfg.rdata = {6'b0, done_flag, fetch.busy};
            default:     cfg.rdata = 8'h00;
        endcase
    end

    a_start_idle : assert property (
        @(posedge clock) disable iff (rst)
        fetch.start |-> !fetch.busy
    ) else $error("display_regs: start issued while the fetcher is busy");

endmodule

/* design/cell_fetcher.sv */
// Word-address sequencer and cell decoder driving the display item stream
`timescale 1ns/1ps

module cell_fetcher (
    input  logic                                    clock,
    input  logic                                    rst,
    fetch_ctrl_if.engine                            fetch,

    output logic [vram_pkg::word_addr_width-1:0]     ram_addr_b,
    input  logic [vram_pkg::word_width-1:0]          ram_q_b,

    output logic                                    item_valid,
    input  logic                                    item_ready,
    output logic [display_pkg::item_code_width-1:0]  item_code,
    output logic [display_pkg::item_color_width-1:0] item_color
);
    import vram_pkg::*;
    import display_pkg::*;

    logic                        busy;
    logic                        done;
    logic [word_addr_width-1:0]  addr_cnt;
    // Count of 0 means 256, hence the extra bit
    logic [8:0]                  remaining;
    display_mode_t               run_mode;
    logic [item_color_width-1:0] run_color;

    // Set when a read went out last cycle and its word is on ram_q_b now
    logic                        rd_pending;
    display_cell_t               rd_cell;
    // Second stage for a word that arrives while the output is stalled
    display_cell_t               skid_q;
    logic                        skid_valid;
    // Output buffer holding one word and the half being shown
    display_cell_t               cell_q;
    logic                        out_valid;
    logic                        half;

    logic                        last_half;
    logic                        pop;
    logic                        load;
    logic [1:0]                  held;
    logic                        issue;
    logic                        finish;

    assign rd_cell   = ram_q_b;
    assign last_half = (run_mode == mode_text) || half;
    // Current word leaves the output buffer on this edge
    assign pop       = out_valid && item_ready && last_half;
    assign load      = !out_valid || pop;

    // Words that will still occupy the pipeline after this edge
    assign held  = {1'b0, rd_pending} + {1'b0, skid_valid} + {1'b0, out_valid && !pop};
    assign issue = busy && (remaining != 9'd0) && (held < 2'd2);

    assign finish = busy && (remaining == 9'd0) && !rd_pending && !skid_valid && pop;

    always_ff @(posedge clock) begin
        if (rst) begin
            busy       <= 1'b0;
            done       <= 1'b0;
            addr_cnt   <= '0;
            remaining  <= '0;
            run_mode   <= mode_text;
            run_color  <= '0;
            rd_pending <= 1'b0;
            skid_valid <= 1'b0;
            out_valid  <= 1'b0;
            half       <= 1'b0;
        end else begin
            done       <= finish;
            rd_pending <= issue;
            if (fetch.start && !busy) begin
                busy      <= 1'b1;
                addr_cnt  <= fetch.base;
                remaining <= (fetch.count == 8'd0) ? 9'd256 : {1'b0, fetch.count};
                run_mode  <= fetch.mode;
                run_color <= fetch.color;
            end else begin
                if (issue) begin
                    // Wraps at the top of the word space
                    addr_cnt  <= addr_cnt + 1'b1;
                    remaining <= remaining - 1'b1;
                end
                if (finish) begin
                    busy <= 1'b0;
                end
            end

            if (load) begin
                out_valid  <= skid_valid || rd_pending;
                half       <= 1'b0;
                skid_valid <= skid_valid && rd_pending;
            end else begin
                if (item_ready) begin
                    half <= 1'b1;
                end
                if (rd_pending) begin
                    skid_valid <= 1'b1;
                end
            end
        end
    end

    // Oldest word goes to the output first
    always_ff @(posedge clock) begin
        if (load) begin
            if (skid_valid) begin
                cell_q <= skid_q;
            end else if (rd_pending) begin
                cell_q <= rd_cell;
            end
        end
        if (rd_pending && (skid_valid || !load)) begin
            skid_q <= rd_cell;
        end
    end

    assign ram_addr_b = addr_cnt;
    assign fetch.busy = busy;
    assign fetch.done = done;

    assign item_valid = out_valid;
    assign item_code  = (run_mode == mode_text) ? cell_q.text.glyph : cell_q.pixel[half];
    assign item_color = (run_mode == mode_text) ? cell_q.text.attr[item_color_width-1:0]
                                                : run_color;

    a_item_stable : assert property (
        @(posedge clock) disable iff (rst)
        (item_valid && !item_ready) |=>
            (item_valid && $stable(item_code) && $stable(item_color))
    ) else $error("cell_fetcher: item changed under back-pressure");

endmodule

/* design/vram_display.sv */
// Top level of the video RAM subsystem with bus slave, RAM, registers and fetcher
`timescale 1ns/1ps

module vram_display (
    input  logic                                    clock,
    input  logic                                    rst,

    input  logic                                    wb_cyc,
    input  logic                                    wb_stb,
    input  logic                                    wb_we,
    input  logic [display_pkg::wb_addr_width-1:0]    wb_adr,
    input  logic [7:0]                              wb_dat_w,
    output logic [7:0]                              wb_dat_r,
    output logic                                    wb_ack,

    output logic                                    item_valid,
    input  logic                                    item_ready,
    output logic [display_pkg::item_code_width-1:0]  item_code,
    output logic [display_pkg::item_color_width-1:0] item_color
);
    import vram_pkg::*;

    logic [byte_addr_width-1:0] ram_addr_a;
    logic [byte_width-1:0]      ram_wdata_a;
    logic                       ram_we_a;
    logic [byte_width-1:0]      ram_q_a;
    logic [word_addr_width-1:0] ram_addr_b;
    logic [word_width-1:0]      ram_q_b;

    cfg_bus_if    cfg_bus ();
    fetch_ctrl_if fetch_ctrl ();

    wb_vram_slave wb_vram_slave_i (
        .clock     (clock),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .ram_addr  (ram_addr_a),
        .ram_wdata (ram_wdata_a),
        .ram_we    (ram_we_a),
        .ram_q     (ram_q_a),
        .cfg       (cfg_bus.master)
    );

    // Port B is read only here
    dpram_dif dpram_dif_i (
        .clock     (clock),
        .address_a (ram_addr_a),
        .data_a    (ram_wdata_a),
        .wren_a    (ram_we_a),
        .q_a       (ram_q_a),
        .address_b (ram_addr_b),
        .data_b    ({word_width{1'b0}}),
        .wren_b    (1'b0),
        .q_b       (ram_q_b)
    );

    display_regs display_regs_i (
        .clock (clock),
        .rst   (rst),
        .cfg   (cfg_bus.target),
        .fetch (fetch_ctrl.ctrl)
    );

    cell_fetcher cell_fetcher_i (
        .clock      (clock),
        .rst        (rst),
        .fetch      (fetch_ctrl.engine),
        .ram_addr_b (ram_addr_b),
        .ram_q_b    (ram_q_b),
        .item_valid (item_valid),
        .item_ready (item_ready),
        .item_code  (item_code),
        .item_color (item_color)
    );

endmodule

/* verification/vram_display_tb.sv */
// Testbench for the video RAM subsystem with stimulus file interpreter, bus tasks and stream checker
`timescale 1ns/1ps

module vram_display_tb;

    localparam int bus_timeout  = 200;
    localparam int wait_timeout = 200;
    // Status register in register space
    localparam logic [12:0] status_addr = 13'h1005;
    localparam string stimulus_file = "verification/vram_display_stimulus.txt";

    logic        clock;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [12:0] wb_adr;
    logic [7:0]  wb_dat_w;
    logic [7:0]  wb_dat_r;
    logic        wb_ack;
    logic        item_valid;
    logic        item_ready;
    logic [7:0]  item_code;
    logic [3:0]  item_color;

    integer seed = 32'h95b03aba;
    int cycle_count = 0;
    int value_errors = 0;
    int timeout_errors = 0;
    int other_errors = 0;

    // Expected items as {code, colour} with the oldest first
    logic [11:0] expected_items[$];

    vram_display vram_display_i (
        .clock      (clock),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .item_valid (item_valid),
        .item_ready (item_ready),
        .item_code  (item_code),
        .item_color (item_color)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("** Error at time %0t: %s expected %0h, got %0h",
                     $time, name, expected, actual);
            value_errors++;
        end
    endtask

    // One classic cycle held until ack and released in the cycle after it
    task automatic bus_access(input logic write, input logic [12:0] addr,
                              input logic [7:0] wdata, output logic [7:0] rdata);
        int cycles;
        cycles = 0;
        rdata = 8'h00;
        @(negedge clock);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = write;
        wb_adr   = addr;
        wb_dat_w = wdata;
        while (!wb_ack && cycles < bus_timeout) begin
            @(negedge clock);
            cycles++;
        end
        if (wb_ack) begin
            rdata = wb_dat_r;
        end else begin
            $display("Bus access to address %h got no acknowledge within %0d cycles",
                     addr, bus_timeout);
            timeout_errors++;
        end
        @(negedge clock);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // Polls status until done, then expects an idle fetcher and an empty list
    task automatic wait_done();
        logic [7:0] status;
        int start_cycle;
        start_cycle = cycle_count;
        status = 8'h00;
        while (!status[1] && (cycle_count - start_cycle) < wait_timeout) begin
            bus_access(1'b0, status_addr, 8'h00, status);
        end
        if (!status[1]) begin
            $display("Fetch done was not seen within %0d cycles", wait_timeout);
            timeout_errors++;
        end else begin
            check_value("status", 16'h0002, {8'h00, status});
            assert (expected_items.size() == 0) else begin
                $display("Fetch ended with %0d expected items never received",
                         expected_items.size());
                other_errors++;
            end
        end
    endtask

    // Random back-pressure and the item check for the coming rising edge
    initial begin
        logic [11:0] expected_item;
        item_ready = 1'b0;
        forever begin
            @(negedge clock);
            item_ready = ($random(seed) & 3) != 0;
            if (item_valid && item_ready) begin
                assert (expected_items.size() > 0) else begin
                    $display("Unexpected stream item %h with colour %h at time %0t",
                             item_code, item_color, $time);
                    other_errors++;
                end
                if (expected_items.size() > 0) begin
                    expected_item = expected_items.pop_front();
                    check_value("item_code", {8'h00, expected_item[11:4]}, {8'h00, item_code});
                    check_value("item_color", {12'h000, expected_item[3:0]},
                                {12'h000, item_color});
                end
            end
        end
    end

    initial begin
        int fd;
        int rc;
        string line;
        byte cmd;
        logic [15:0] arg_a;
        logic [15:0] arg_b;
        logic [7:0] rdata;
        rst = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        repeat (3) @(negedge clock);
        rst = 1'b0;
        @(negedge clock);
        check_value("wb_ack", 16'h0000, {15'h0000, wb_ack});
        check_value("item_valid", 16'h0000, {15'h0000, item_valid});

        fd = $fopen(stimulus_file, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", stimulus_file);
            other_errors++;
        end else begin
            rc = $fgets(line, fd);
            while (rc != 0) begin
                cmd = "#";
                void'($sscanf(line, "%c %h %h", cmd, arg_a, arg_b));
                case (cmd)
                    "W": bus_access(1'b1, arg_a[12:0], arg_b[7:0], rdata);
                    "R": begin
                        bus_access(1'b0, arg_a[12:0], 8'h00, rdata);
                        check_value($sformatf("wb_dat_r[%h]", arg_a[12:0]),
                                    {8'h00, arg_b[7:0]}, {8'h00, rdata});
                    end
                    "S": expected_items.push_back({arg_a[7:0], arg_b[3:0]});
                    "D": wait_done();
                    "#", 8'h0a, 8'h0d, " ": ;
                    default: begin
                        $display("Unknown stimulus command '%c' in line: %s", cmd, line);
                        other_errors++;
                    end
                endcase
                rc = $fgets(line, fd);
            end
            $fclose(fd);
        end

        $display("Errors: %0d value mismatches, %0d timeouts, %0d other failures",
                 value_errors, timeout_errors, other_errors);
        if (value_errors + timeout_errors + other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* verification/vram_display_stimulus.txt */
# Columns: command, address or item code, data or expected value or item colour (hex)
# W write, R read and compare, S expected stream item, D wait for status done
# RAM bytes, including the last address
W 0000 a5
W 0fff 3c
W 0010 5a
R 0000 a5
R 0fff 3c
R 0010 5a
# Registers, status is clear after reset
R 1005 00
W 1001 34
W 1002 05
W 1003 09
W 1004 0c
R 1001 34
R 1002 05
R 1003 09
R 1004 0c
# Text mode, three words from word 0x010
W 0020 41
W 0021 1e
W 0022 42
W 0023 27
W 0024 43
W 0025 f3
W 1001 10
W 1002 00
W 1003 03
S 41 e
S 42 7
S 43 3
W 1000 01
D
# Pixel mode across the wrap from word 0x7ff to word 0
W 0ffe 11
W 0001 22
W 1001 ff
W 1002 07
W 1003 02
W 1004 09
S 11 9
S 3c 9
S a5 9
S 22 9
W 1000 03
D
R 1000 02
# Byte changed in a fetched word shows up in the next fetch
W 0000 66
S 11 9
S 3c 9
S 66 9
S 22 9
W 1000 03
D
R 1005 02

/* vram_display.f */
design/vram_pkg.sv
design/display_pkg.sv
design/cfg_bus_if.sv
design/fetch_ctrl_if.sv
design/dpram_dif.sv
design/wb_vram_slave.sv
design/display_regs.sv
design/cell_fetcher.sv
design/vram_display.sv
verification/vram_display_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the vram_display testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module vram_display_tb \
    -f vram_display.f --Mdir obj_dir -o vram_display_sim
./obj_dir/vram_display_sim | tee sim.log

if grep -q "PASS: all tests" sim.log; then
    exit 0
fi
exit 1
